/* compile.f */
src/icache_geom_pkg.sv
src/icache_ctrl_pkg.sv
src/icache_tag_ram.sv
src/icache_data_ram.sv
src/icache_age_table.sv
src/icache_ctrl.sv
src/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

/* sim/icache_mem_model.sv */
/*
 * icache memory responder
 * answers each request with a one-cycle acknowledge after a random
 * delay of 0 to 7 cycles, data derived from the address
 */
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model
    import icache_geom_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_req,
    input  wire logic [ADDR_W-1:0] i_addr,
    output logic                   o_ack,
    output logic      [DATA_W-1:0] o_data
);

    integer     seed = 1142;
    logic       busy;
    logic [2:0] wait_cnt;

    // word content of a line, offset bits ignored
    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] lo;
        logic [DATA_W-1:0] hi;
        lo = addr[34:3];
        hi = {addr[63:35], 3'b101};
        return (lo * 32'h9e37_79b1) ^ hi;
    endfunction

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            o_ack    <= 1'b0;
            o_data   <= '0;
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else begin
            o_ack <= 1'b0;
            if (o_ack) begin
                // request drops at this edge
                busy <= 1'b0;
            end else if (i_req && !busy) begin
                busy     <= 1'b1;
                wait_cnt <= 3'($random(seed));
            end else if (busy) begin
                if (wait_cnt == 3'd0) begin
                    o_ack  <= 1'b1;
                    o_data <= mem_word(i_addr);
                end else begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/icache_tb.sv */
/*
 * icache testbench
 * directed and random fetches against a reference model of tags,
 * valid bits and ages, with a checker on the fetch and memory ports
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tb
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int N_RAND        = 200;
    localparam int N_FETCH       = N_RAND + 16;
    localparam int FETCH_TIMEOUT = 16;

    logic              clk;
    logic              rst;
    logic              fetch_en;
    logic [ADDR_W-1:0] fetch_addr;
    logic              fetch_valid;
    logic [DATA_W-1:0] fetch_data;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_ack;
    logic [DATA_W-1:0] mem_data;

    integer seed = 1142;
    int     word_errs;
    int     hit_errs;
    int     way_errs;
    int     other_errs;

    // expectations of outstanding fetches
    logic [ADDR_W-1:0] exp_addr_q [$];
    logic [DATA_W-1:0] exp_word_q [$];
    logic              exp_hit_q [$];
    logic [ADDR_W-1:0] cur_addr;
    logic [DATA_W-1:0] cur_word;
    logic              cur_hit;

    // reference cache state
    logic [TAG_W-1:0] ref_tag [2][SETS];
    logic             ref_valid [2][SETS];
    logic [AGE_W-1:0] ref_age [2][SETS];

    logic              last_miss;
    icache_way_e       last_way;
    int                req_rises;
    logic              req_prev;
    logic [ADDR_W-1:0] addr_prev;

    icache_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_en    (fetch_en),
        .i_fetch_addr  (fetch_addr),
        .o_fetch_valid (fetch_valid),
        .o_fetch_data  (fetch_data),
        .o_mem_req     (mem_req),
        .o_mem_addr    (mem_addr),
        .i_mem_ack     (mem_ack),
        .i_mem_data    (mem_data)
    );

    icache_mem_model mem_i (
        .clk    (clk),
        .rst    (rst),
        .i_req  (mem_req),
        .i_addr (mem_addr),
        .o_ack  (mem_ack),
        .o_data (mem_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // same content rule as the memory responder
    function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] lo;
        logic [DATA_W-1:0] hi;
        lo = addr[34:3];
        hi = {addr[63:35], 3'b101};
        return (lo * 32'h9e37_79b1) ^ hi;
    endfunction

    function automatic void clear_model();
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < SETS; s++) begin
                ref_tag[w][s]   = '0;
                ref_valid[w][s] = 1'b0;
                ref_age[w][s]   = '0;
            end
        end
    endfunction

    // ages everything, looks up the set, picks and fills a victim on a miss
    function automatic logic [DATA_W-1:0] predict_fetch(input logic [ADDR_W-1:0] addr,
                                                        output logic hit,
                                                        output icache_way_e way);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        idx = addr[INDEX_LSB +: INDEX_W];
        tag = addr[ADDR_W-1:TAG_LSB];
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < SETS; s++) begin
                if (ref_age[w][s] != AGE_MAX) begin
                    ref_age[w][s] = ref_age[w][s] + 1'b1;
                end
            end
        end
        hit = 1'b0;
        way = WAY0;
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
                hit = 1'b1;
                way = icache_way_e'(w);
            end
        end
        if (!hit) begin
            if (!ref_valid[0][idx]) way = WAY0;
            else if (!ref_valid[1][idx]) way = WAY1;
            else if (ref_age[1][idx] > ref_age[0][idx]) way = WAY1;
            else way = WAY0;
            ref_tag[int'(way)][idx]   = tag;
            ref_valid[int'(way)][idx] = 1'b1;
        end
        ref_age[int'(way)][idx] = '0;
        return mem_word(addr);
    endfunction

    // three tags competing for two ways in a few sets
    function automatic logic [ADDR_W-1:0] rand_addr();
        int               r;
        logic [TAG_W-1:0] tag;
        r = $random(seed);
        case (r[1:0])
            2'd0:    tag = 55'h5;
            2'd1:    tag = 55'h40_0000_0000_0005;
            default: tag = 55'h12;
        endcase
        return {tag, INDEX_W'(r[5:4]), 3'b000};
    endfunction

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            word_errs++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            hit_errs++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_way(input string name, input icache_way_e got,
                             input icache_way_e exp);
        if (got !== exp) begin
            way_errs++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            other_errs++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reset_dut();
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        clear_model();
    endtask

    // one strobe and the wait for its answer
    task automatic fetch(input logic [ADDR_W-1:0] addr);
        logic        exp_hit;
        icache_way_e exp_way;
        int          cycles;
        exp_word_q.push_back(predict_fetch(addr, exp_hit, exp_way));
        exp_hit_q.push_back(exp_hit);
        exp_addr_q.push_back(addr);
        last_way = exp_way;
        @(posedge clk);
        fetch_en   <= 1'b1;
        fetch_addr <= addr;
        @(posedge clk);
        fetch_en <= 1'b0;
        cycles = 0;
        while (!fetch_valid && cycles < FETCH_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!fetch_valid) begin
            $display("no o_fetch_valid within %0d cycles for address %h", cycles, addr);
            $display("TESTBENCH FAILED");
            $finish;
        end
        // checker records the outcome on this edge
        @(posedge clk);
        if (!last_miss && cycles != 3) begin
            other_errs++;
            $display("hit answered %0d cycles after the strobe instead of 3", cycles);
        end
    endtask

    // fetch and memory port checker
    always @(posedge clk) begin
        if (rst) begin
            if (mem_req && !req_prev) begin
                req_rises++;
                if (exp_addr_q.size() == 0) begin
                    other_errs++;
                    $display("memory request raised with no fetch outstanding");
                end else begin
                    check_addr("o_mem_addr", mem_addr, exp_addr_q[0]);
                end
            end else if (mem_req && req_prev) begin
                check_addr("o_mem_addr held", mem_addr, addr_prev);
            end
            if (fetch_valid) begin
                if (exp_word_q.size() == 0) begin
                    other_errs++;
                    $display("o_fetch_valid pulse with no fetch outstanding");
                end else begin
                    cur_word = exp_word_q.pop_front();
                    cur_hit  = exp_hit_q.pop_front();
                    cur_addr = exp_addr_q.pop_front();
                    check_word("o_fetch_data", fetch_data, cur_word);
                    check_hit("hit", req_rises == 0, cur_hit);
                    if (req_rises > 1) begin
                        other_errs++;
                        $display("fetch of %h raised the memory request %0d times",
                                 cur_addr, req_rises);
                    end
                    last_miss = (req_rises != 0);
                    req_rises = 0;
                end
            end
        end
        req_prev  <= mem_req;
        addr_prev <= mem_addr;
    end

    // hard limit on the whole run
    initial begin
        #(CLK_PERIOD * (N_FETCH * (FETCH_TIMEOUT + 4) + 100));
        $display("watchdog expired before the test sequence finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [ADDR_W-1:0] addr_a;
        logic [ADDR_W-1:0] addr_b;
        logic [ADDR_W-1:0] addr_c;
        icache_way_e       way_a;
        icache_way_e       way_b;
        icache_way_e       victim;
        int                gap;
        clk        = 1'b0;
        rst        = 1'b0;
        fetch_en   = 1'b0;
        fetch_addr = '0;
        word_errs  = 0;
        hit_errs   = 0;
        way_errs   = 0;
        other_errs = 0;
        req_rises  = 0;
        last_miss  = 1'b0;
        addr_a = {55'h1, 6'd9, 3'b000};
        addr_b = {55'h2, 6'd9, 3'b000};
        addr_c = {55'h3, 6'd9, 3'b000};
        reset_dut();

        // cold miss followed by a hit
        fetch(addr_a);
        way_a = last_way;
        fetch(addr_a);
        // second tag in the same set fills the other way
        fetch(addr_b);
        way_b = last_way;
        fetch(addr_a);
        fetch(addr_b);
        // third tag evicts by age
        fetch(addr_c);
        victim = last_way;
        // kept address hits and the evicted one misses
        fetch(addr_b);
        check_way("victim way", last_miss ? way_b : way_a, victim);
        fetch(addr_a);

        for (int i = 0; i < N_RAND; i++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(posedge clk);
            fetch(rand_addr());
        end

        // everything misses again after reset
        @(posedge clk);
        reset_dut();
        fetch(addr_a);
        fetch(addr_b);
        fetch(addr_c);
        fetch(addr_c);

        repeat (4) @(posedge clk);
        if (exp_word_q.size() != 0) begin
            other_errs++;
            $display("%0d fetches never answered", exp_word_q.size());
        end
        $display("errors: data %0d, hit %0d, way %0d, other %0d",
                 word_errs, hit_errs, way_errs, other_errs);
        if (word_errs + hit_errs + way_errs + other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/icache_age_table.sv */
/*
 * icache age table
 * saturating age per way and set, cleared on use, and victim choice
 */
`timescale 1ns/1ps
`default_nettype none

module icache_age_table
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [INDEX_W-1:0] i_index,
    input  wire logic               i_tick,
    input  wire logic               i_touch,
    input  wire icache_way_e        i_touch_way,
    input  wire logic               i_valid0,
    input  wire logic               i_valid1,
    output icache_way_e             o_victim
);

    logic [AGE_W-1:0] age0 [SETS];
    logic [AGE_W-1:0] age1 [SETS];

    function automatic logic [AGE_W-1:0] sat_inc(input logic [AGE_W-1:0] a);
        if (a == AGE_W'(AGE_MAX)) begin
            return a;
        end
        return a + 1'b1;
    endfunction

    // tick ages every entry, touch clears one
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                age0[s] <= '0;
                age1[s] <= '0;
            end
        end else if (i_tick) begin
            for (int s = 0; s < SETS; s++) begin
                age0[s] <= sat_inc(age0[s]);
                age1[s] <= sat_inc(age1[s]);
            end
        end else if (i_touch) begin
            if (i_touch_way == WAY0) begin
                age0[i_index] <= '0;
            end else begin
                age1[i_index] <= '0;
            end
        end
    end

    // empty way first, then the older one, way 0 on a tie
    always_comb begin
        if (!i_valid0) begin
            o_victim = WAY0;
        end else if (!i_valid1) begin
            o_victim = WAY1;
        end else if (age1[i_index] > age0[i_index]) begin
            o_victim = WAY1;
        end else begin
            o_victim = WAY0;
        end
    end

    // ticks come from idle, touches from compare or miss wait
    a_tick_touch_excl: assert property (
        @(posedge clk) disable iff (!rst)
        !(i_tick && i_touch)
    );

endmodule

`default_nettype wire

/* src/icache_ctrl.sv */
/*
 * icache controller
 * fetch FSM with tag compare, way select on hit and
 * single-word refill from memory on a miss
 */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,

    // fetch side
    input  wire logic               i_fetch_en,
    input  wire logic [ADDR_W-1:0]  i_fetch_addr,
    output logic                    o_fetch_valid,
    output logic      [DATA_W-1:0]  o_fetch_data,

    // memory side
    output logic                    o_mem_req,
    output logic      [ADDR_W-1:0]  o_mem_addr,
    input  wire logic               i_mem_ack,
    input  wire logic [DATA_W-1:0]  i_mem_data,

    // RAM control
    output logic      [INDEX_W-1:0] o_index,
    output logic      [TAG_W-1:0]   o_wtag,
    output logic      [DATA_W-1:0]  o_wdata,
    output logic                    o_we0,
    output logic                    o_we1,
    input  wire logic [TAG_W-1:0]   i_tag0,
    input  wire logic               i_valid0,
    input  wire logic [TAG_W-1:0]   i_tag1,
    input  wire logic               i_valid1,
    input  wire logic [DATA_W-1:0]  i_rdata0,
    input  wire logic [DATA_W-1:0]  i_rdata1,

    // age table
    input  wire icache_way_e        i_victim,
    output logic                    o_tick,
    output logic                    o_touch,
    output icache_way_e             o_touch_way
);

    icache_state_e    state_q;
    icache_state_e    state_d;
    logic [ADDR_W-1:0] addr_q;
    icache_way_e      victim_q;
    logic [TAG_W-1:0] req_tag;
    logic             accept;
    logic             hit0;
    logic             hit1;
    logic             hit;
    logic             miss;
    logic             fill;

    assign req_tag = addr_q[ADDR_W-1:TAG_LSB];
    assign accept  = (state_q == IDLE) && i_fetch_en;

    // tag compare, RAM outputs line up with COMPARE
    assign hit0 = i_valid0 && (i_tag0 == req_tag);
    assign hit1 = i_valid1 && (i_tag1 == req_tag);
    assign hit  = (state_q == COMPARE) && (hit0 || hit1);
    assign miss = (state_q == COMPARE) && !(hit0 || hit1);
    assign fill = (state_q == MISS_WAIT) && i_mem_ack;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (i_fetch_en) state_d = READ;
            READ:      state_d = COMPARE;
            COMPARE:   state_d = hit ? IDLE : MISS_WAIT;
            MISS_WAIT: if (i_mem_ack) state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q       <= IDLE;
            addr_q        <= '0;
            victim_q      <= WAY0;
            o_fetch_valid <= 1'b0;
            o_mem_req     <= 1'b0;
        end else begin
            state_q       <= state_d;
            o_fetch_valid <= hit || fill;
            if (accept) begin
                addr_q <= i_fetch_addr;
            end
            // victim is frozen for the whole refill
            if (miss) begin
                victim_q  <= i_victim;
                o_mem_req <= 1'b1;
            end else if (fill) begin
                o_mem_req <= 1'b0;
            end
        end
    end

    // returned word, from the hitting way or straight from memory
    always_ff @(posedge clk) begin
        if (hit) begin
            o_fetch_data <= hit1 ? i_rdata1 : i_rdata0;
        end else if (fill) begin
            o_fetch_data <= i_mem_data;
        end
    end

    assign o_mem_addr = addr_q;

    // RAM side
    assign o_index = addr_q[INDEX_LSB +: INDEX_W];
    assign o_wtag  = req_tag;
    assign o_wdata = i_mem_data;
    assign o_we0   = fill && (victim_q == WAY0);
    assign o_we1   = fill && (victim_q == WAY1);

    // age bookkeeping
    assign o_tick      = accept;
    assign o_touch     = hit || fill;
    assign o_touch_way = (state_q == COMPARE) ? (hit1 ? WAY1 : WAY0) : victim_q;

    // requester waits for o_fetch_valid before the next strobe
    a_fetch_only_idle: assert property (
        @(posedge clk) disable iff (!rst)
        i_fetch_en |-> state_q == IDLE
    );

    // request and address hold until the memory answers
    a_mem_req_hold: assert property (
        @(posedge clk) disable iff (!rst)
        o_mem_req && !i_mem_ack |=> o_mem_req && $stable(o_mem_addr)
    );

    // a fill never duplicates a line already present in the set
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst)
        state_q == COMPARE |-> !(hit0 && hit1)
    );

endmodule

`default_nettype wire

/* src/icache_ctrl_pkg.sv */
/*
 * icache control types
 * controller states and way selection shared by the controller
 * and the age table
 */
`default_nettype none

package icache_ctrl_pkg;

    // fetch FSM
    typedef enum logic [1:0] {
        IDLE,
        READ,
        COMPARE,
        MISS_WAIT
    } icache_state_e;

    // one of the two ways
    typedef enum logic {
        WAY0,
        WAY1
    } icache_way_e;

endpackage

`default_nettype wire

/* src/icache_data_ram.sv */
/*
 * icache data RAM
 * one instruction word per set for a single way
 */
`timescale 1ns/1ps
`default_nettype none

module icache_data_ram
    import icache_geom_pkg::*;
(
    input  wire logic               clk,
    input  wire logic [INDEX_W-1:0] i_index,
    input  wire logic               i_we,
    input  wire logic [DATA_W-1:0]  i_wdata,
    output logic      [DATA_W-1:0]  o_rdata
);

    logic [DATA_W-1:0] data_mem [SETS];

    // write port
    always_ff @(posedge clk) begin
        if (i_we) begin
            data_mem[i_index] <= i_wdata;
        end
    end

    // registered read, one cycle after the index
    always_ff @(posedge clk) begin
        o_rdata <= data_mem[i_index];
    end

endmodule

`default_nettype wire

/* src/icache_geom_pkg.sv */
/*
 * icache geometry
 * address split, word width and age counter sizing for the
 * two-way instruction cache
 */
`default_nettype none

package icache_geom_pkg;

    // fetch address and instruction word
    localparam int ADDR_W = 64;
    localparam int DATA_W = 32;

    // set index sits right above the word offset
    localparam int INDEX_W   = 6;
    localparam int INDEX_LSB = 3;

    // everything above the index is tag
    localparam int TAG_LSB = INDEX_LSB + INDEX_W;
    localparam int TAG_W   = ADDR_W - TAG_LSB;

    // one line per set and way
    localparam int SETS = 1 << INDEX_W;

    // per-way age, saturating
    localparam int AGE_W   = 3;
    localparam int AGE_MAX = (1 << AGE_W) - 1;

endpackage

`default_nettype wire

/* src/icache_tag_ram.sv */
/*
 * icache tag RAM
 * tag store for one way with a valid flag per set, synchronous read
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_ram
    import icache_geom_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [INDEX_W-1:0] i_index,
    input  wire logic               i_we,
    input  wire logic [TAG_W-1:0]   i_wtag,
    output logic      [TAG_W-1:0]   o_tag,
    output logic                    o_valid
);

    logic [TAG_W-1:0] tag_mem [SETS];
    logic [SETS-1:0]  valid_q;

    // tag array, contents only meaningful under valid
    always_ff @(posedge clk) begin
        if (i_we) begin
            tag_mem[i_index] <= i_wtag;
        end
        o_tag <= tag_mem[i_index];
    end

    // valid flags, cleared on reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            o_valid <= 1'b0;
        end else begin
            if (i_we) begin
                valid_q[i_index] <= 1'b1;
            end
            // read returns the old flag on a same-cycle write
            o_valid <= valid_q[i_index];
        end
    end

    // a fill must always land on a known set
    a_we_index_known: assert property (
        @(posedge clk) disable iff (!rst)
        i_we |-> !$isunknown(i_index)
    );

endmodule

`default_nettype wire

/* src/icache_top.sv */
/*
 * icache top
 * two-way set-associative instruction cache, 64 sets of one word
 */
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_fetch_en,
    input  wire logic [ADDR_W-1:0] i_fetch_addr,
    output logic                   o_fetch_valid,
    output logic      [DATA_W-1:0] o_fetch_data,
    output logic                   o_mem_req,
    output logic      [ADDR_W-1:0] o_mem_addr,
    input  wire logic              i_mem_ack,
    input  wire logic [DATA_W-1:0] i_mem_data
);

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   wtag;
    logic [DATA_W-1:0]  wdata;
    logic               we0;
    logic               we1;
    logic [TAG_W-1:0]   tag0;
    logic [TAG_W-1:0]   tag1;
    logic               valid0;
    logic               valid1;
    logic [DATA_W-1:0]  rdata0;
    logic [DATA_W-1:0]  rdata1;
    icache_way_e        victim;
    logic               tick;
    logic               touch;
    icache_way_e        touch_way;

    icache_ctrl ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .i_fetch_en    (i_fetch_en),
        .i_fetch_addr  (i_fetch_addr),
        .o_fetch_valid (o_fetch_valid),
        .o_fetch_data  (o_fetch_data),
        .o_mem_req     (o_mem_req),
        .o_mem_addr    (o_mem_addr),
        .i_mem_ack     (i_mem_ack),
        .i_mem_data    (i_mem_data),
        .o_index       (index),
        .o_wtag        (wtag),
        .o_wdata       (wdata),
        .o_we0         (we0),
        .o_we1         (we1),
        .i_tag0        (tag0),
        .i_valid0      (valid0),
        .i_tag1        (tag1),
        .i_valid1      (valid1),
        .i_rdata0      (rdata0),
        .i_rdata1      (rdata1),
        .i_victim      (victim),
        .o_tick        (tick),
        .o_touch       (touch),
        .o_touch_way   (touch_way)
    );

    // way 0
    icache_tag_ram tag0_i (
        .clk     (clk),
        .rst     (rst),
        .i_index (index),
        .i_we    (we0),
        .i_wtag  (wtag),
        .o_tag   (tag0),
        .o_valid (valid0)
    );

    icache_data_ram data0_i (
        .clk     (clk),
        .i_index (index),
        .i_we    (we0),
        .i_wdata (wdata),
        .o_rdata (rdata0)
    );

    // way 1
    icache_tag_ram tag1_i (
        .clk     (clk),
        .rst     (rst),
        .i_index (index),
        .i_we    (we1),
        .i_wtag  (wtag),
        .o_tag   (tag1),
        .o_valid (valid1)
    );

    icache_data_ram data1_i (
        .clk     (clk),
        .i_index (index),
        .i_we    (we1),
        .i_wdata (wdata),
        .o_rdata (rdata1)
    );

    icache_age_table age_i (
        .clk         (clk),
        .rst         (rst),
        .i_index     (index),
        .i_tick      (tick),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .i_valid0    (valid0),
        .i_valid1    (valid1),
        .o_victim    (victim)
    );

endmodule

`default_nettype wire
